// File: common/poker_params.svh
`ifndef POKER_PARAMS_SVH
`define POKER_PARAMS_SVH

// Money path width and table economics.
`define MONEY_W        7
`define START_BALANCE  49
`define RAISE_STEP     5

// APB address width.
`define APB_AW         5

// Register map.
`define ACTION_ADDR    5'h00
`define CONTROL_ADDR   5'h04
`define SHOWDOWN_ADDR  5'h08
`define STATUS_ADDR    5'h0C
`define BALANCE_ADDR   5'h10

`endif

// File: common/poker_pkg.sv
`include "poker_params.svh"

package poker_pkg;

    typedef enum logic [1:0] {playing, cashout, freeze} table_state_t;

    typedef enum logic [1:0] {preflop, flop, turn, river} round_t;

    typedef enum logic {p1, p2} player_t;

    typedef enum logic [1:0] {
        act_none  = 2'd0,
        act_fold  = 2'd1,
        act_call  = 2'd2,
        act_raise = 2'd3
    } action_t;

    // How the pot is paid out after the payment lands.
    typedef enum logic [1:0] {award_none, award_fold, award_showdown, award_split} award_t;

    typedef struct packed {
        logic                psel;
        logic                penable;
        logic                pwrite;
        logic [`APB_AW-1:0]  paddr;
        logic [31:0]         pwdata;
    } apb_req_s;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_s;

    typedef struct packed {
        logic                valid;
        player_t             payer;
        logic [`MONEY_W-1:0] amount;
        award_t              award;
        player_t             winner;
    } transfer_s;

    typedef struct packed {
        logic p1_wins;
        logic tie;
    } showdown_s;

    typedef struct packed {
        logic [`MONEY_W-1:0] p1_balance;
        logic [`MONEY_W-1:0] p2_balance;
        logic [`MONEY_W-1:0] pot;
    } ledger_s;

    typedef struct packed {
        round_t              round;
        player_t             cur_player;
        player_t             start_player;
        logic [`MONEY_W-1:0] cur_bet;
        logic                hand_parity;
    } bet_status_s;

endpackage

// File: logic/apb_table_regs.sv
`timescale 1ns/10ps
`include "poker_params.svh"

module apb_table_regs (
    input  logic                    clk,
    input  logic                    reset_d,
    input  poker_pkg::apb_req_s     apb_req,
    output poker_pkg::apb_rsp_s     apb_rsp,
    output logic                    action_strobe,
    output poker_pkg::action_t      action,
    input  logic                    action_ok,
    output logic                    cashout_req,
    output logic                    freeze_req,
    output poker_pkg::showdown_s    showdown,
    input  poker_pkg::table_state_t table_state,
    input  poker_pkg::bet_status_s  bet_status,
    input  poker_pkg::ledger_s      ledger
);

    logic        access;
    logic        wr;
    logic        rd;
    logic        addr_hit;
    logic [31:0] rdata;

    // Access phase of a transfer.
    assign access = apb_req.psel && apb_req.penable;
    assign wr     = access && apb_req.pwrite;
    assign rd     = access && !apb_req.pwrite;

    assign action_strobe = wr && (apb_req.paddr == `ACTION_ADDR);
    assign action        = poker_pkg::action_t'(apb_req.pwdata[1:0]);

    always_ff @(posedge clk or posedge reset_d) begin
        if (reset_d) begin
            cashout_req <= 1'b0;
            freeze_req  <= 1'b0;
            showdown    <= '0;
        end else if (wr) begin
            if (apb_req.paddr == `CONTROL_ADDR) begin
                cashout_req <= apb_req.pwdata[0];
                freeze_req  <= apb_req.pwdata[1];
            end
            if (apb_req.paddr == `SHOWDOWN_ADDR) begin
                showdown <= poker_pkg::showdown_s'(apb_req.pwdata[1:0]);
            end
        end
    end

    always_comb begin
        addr_hit = 1'b1;
        rdata    = '0;
        case (apb_req.paddr)
            `ACTION_ADDR, `CONTROL_ADDR, `SHOWDOWN_ADDR: begin
                rdata = '0;
            end
            `STATUS_ADDR: begin
                rdata[1:0]   = table_state;
                rdata[3:2]   = bet_status.round;
                rdata[4]     = bet_status.cur_player;
                rdata[11:5]  = bet_status.cur_bet;
                rdata[18:12] = ledger.pot;
            end
            `BALANCE_ADDR: begin
                rdata[6:0]  = ledger.p1_balance;
                rdata[14:8] = ledger.p2_balance;
            end
            default: begin
                addr_hit = 1'b0;
            end
        endcase
    end

    assign apb_rsp.prdata = rd ? rdata : 32'd0;
    assign apb_rsp.pready = 1'b1;

    // Rejected actions and writes to holes in the map.
    assign apb_rsp.pslverr = (action_strobe && !action_ok) || (wr && !addr_hit);

endmodule

// File: logic/table_control.sv
`timescale 1ns/10ps

module table_control (
    input  logic                    clk,
    input  logic                    reset_d,
    input  logic                    cashout_req,
    input  logic                    freeze_req,
    input  logic                    hand_idle,
    output poker_pkg::table_state_t table_state,
    output logic                    new_table
);

    poker_pkg::table_state_t next_state;
    poker_pkg::table_state_t saved_state;

    always_comb begin
        next_state = table_state;
        case (table_state)
            poker_pkg::playing: begin
                if (freeze_req)
                    next_state = poker_pkg::freeze;
                else if (cashout_req && hand_idle)
                    next_state = poker_pkg::cashout;
            end
            poker_pkg::cashout: begin
                if (freeze_req)
                    next_state = poker_pkg::freeze;
                else if (!cashout_req)
                    next_state = poker_pkg::playing;
            end
            default: begin
                if (!freeze_req)
                    next_state = saved_state;
            end
        endcase
    end

    // Fresh balances on the edge that leaves cashout.
    assign new_table = (table_state == poker_pkg::cashout) &&
                       (next_state == poker_pkg::playing);

    always_ff @(posedge clk or posedge reset_d) begin
        if (reset_d) begin
            table_state <= poker_pkg::playing;
            saved_state <= poker_pkg::playing;
        end else begin
            table_state <= next_state;
            if (next_state == poker_pkg::freeze && table_state != poker_pkg::freeze)
                saved_state <= table_state;
        end
    end

endmodule

// File: betting/betting_engine.sv
`timescale 1ns/10ps
`include "poker_params.svh"

module betting_engine (
    input  logic                    clk,
    input  logic                    reset_d,
    input  logic                    action_strobe,
    input  poker_pkg::action_t      action,
    input  poker_pkg::table_state_t table_state,
    input  logic                    new_table,
    input  poker_pkg::showdown_s    showdown,
    output poker_pkg::transfer_s    transfer,
    input  logic                    accept,
    output logic                    action_ok,
    output logic                    hand_idle,
    output poker_pkg::bet_status_s  bet_status
);

    poker_pkg::round_t   round;
    poker_pkg::player_t  cur_player;
    logic                hand_parity;
    logic [`MONEY_W-1:0] cur_bet;
    logic [`MONEY_W-1:0] p1_committed;
    logic [`MONEY_W-1:0] p2_committed;

    poker_pkg::player_t  start_player;
    poker_pkg::player_t  other_player;
    logic [`MONEY_W-1:0] call_amt;
    logic [`MONEY_W-1:0] raised_bet;
    logic                advance;
    logic                end_hand;

    assign start_player = poker_pkg::player_t'(hand_parity);
    assign other_player = poker_pkg::player_t'(~cur_player);
    assign call_amt     = cur_bet - ((cur_player == poker_pkg::p1) ? p1_committed : p2_committed);
    assign raised_bet   = cur_bet + `MONEY_W'(`RAISE_STEP);

    always_comb begin
        transfer        = '0;
        transfer.valid  = action_strobe && (table_state == poker_pkg::playing) &&
                          (action != poker_pkg::act_none);
        transfer.payer  = cur_player;
        transfer.award  = poker_pkg::award_none;
        transfer.winner = poker_pkg::p1;
        advance         = 1'b0;
        end_hand        = 1'b0;
        case (action)
            poker_pkg::act_fold: begin
                transfer.award  = poker_pkg::award_fold;
                transfer.winner = other_player;
                end_hand        = 1'b1;
            end
            poker_pkg::act_call: begin
                if (cur_bet != '0) begin
                    transfer.amount = call_amt;
                    advance         = 1'b1;
                end else begin
                    advance = (cur_player != start_player);
                end
                // Closing the river goes to showdown.
                if (advance && round == poker_pkg::river) begin
                    end_hand = 1'b1;
                    if (showdown.tie) begin
                        transfer.award = poker_pkg::award_split;
                    end else begin
                        transfer.award  = poker_pkg::award_showdown;
                        transfer.winner = showdown.p1_wins ? poker_pkg::p1 : poker_pkg::p2;
                    end
                end
            end
            poker_pkg::act_raise: begin
                transfer.amount = call_amt + `MONEY_W'(`RAISE_STEP);
            end
            default: begin
            end
        endcase
    end

    assign action_ok = transfer.valid && accept;

    always_ff @(posedge clk or posedge reset_d) begin
        if (reset_d) begin
            round        <= poker_pkg::preflop;
            cur_player   <= poker_pkg::p1;
            hand_parity  <= 1'b0;
            cur_bet      <= '0;
            p1_committed <= '0;
            p2_committed <= '0;
        end else if (new_table) begin
            round        <= poker_pkg::preflop;
            cur_player   <= poker_pkg::p1;
            hand_parity  <= 1'b0;
            cur_bet      <= '0;
            p1_committed <= '0;
            p2_committed <= '0;
        end else if (action_ok) begin
            if (end_hand) begin
                round        <= poker_pkg::preflop;
                cur_player   <= poker_pkg::player_t'(~hand_parity);
                hand_parity  <= ~hand_parity;
                cur_bet      <= '0;
                p1_committed <= '0;
                p2_committed <= '0;
            end else if (advance) begin
                round        <= poker_pkg::round_t'(round + 2'd1);
                cur_player   <= start_player;
                cur_bet      <= '0;
                p1_committed <= '0;
                p2_committed <= '0;
            end else if (action == poker_pkg::act_raise) begin
                cur_bet    <= raised_bet;
                cur_player <= other_player;
                if (cur_player == poker_pkg::p1)
                    p1_committed <= raised_bet;
                else
                    p2_committed <= raised_bet;
            end else begin
                // Start player checked.
                cur_player <= other_player;
            end
        end
    end

    assign hand_idle = (round == poker_pkg::preflop) && (cur_bet == '0);

    assign bet_status.round        = round;
    assign bet_status.cur_player   = cur_player;
    assign bet_status.start_player = start_player;
    assign bet_status.cur_bet      = cur_bet;
    assign bet_status.hand_parity  = hand_parity;

endmodule

// File: betting/chip_ledger.sv
`timescale 1ns/10ps
`include "poker_params.svh"

module chip_ledger (
    input  logic                 clk,
    input  logic                 reset_d,
    input  logic                 new_table,
    input  poker_pkg::transfer_s transfer,
    output logic                 accept,
    output poker_pkg::ledger_s   ledger
);

    logic [`MONEY_W-1:0] p1_balance;
    logic [`MONEY_W-1:0] p2_balance;
    logic [`MONEY_W-1:0] pot;

    logic [`MONEY_W-1:0] payer_balance;
    logic [`MONEY_W-1:0] p1_paid;
    logic [`MONEY_W-1:0] p2_paid;
    logic [`MONEY_W-1:0] pot_paid;
    logic [`MONEY_W-1:0] half_pot;

    assign payer_balance = (transfer.payer == poker_pkg::p1) ? p1_balance : p2_balance;

    // No credit at this table.
    assign accept = transfer.valid && (transfer.amount <= payer_balance);

    always_comb begin
        p1_paid = p1_balance;
        p2_paid = p2_balance;
        if (transfer.payer == poker_pkg::p1)
            p1_paid = p1_balance - transfer.amount;
        else
            p2_paid = p2_balance - transfer.amount;
        pot_paid = pot + transfer.amount;
        half_pot = pot_paid >> 1;
    end

    always_ff @(posedge clk or posedge reset_d) begin
        if (reset_d) begin
            p1_balance <= `MONEY_W'(`START_BALANCE);
            p2_balance <= `MONEY_W'(`START_BALANCE);
            pot        <= '0;
        end else if (new_table) begin
            p1_balance <= `MONEY_W'(`START_BALANCE);
            p2_balance <= `MONEY_W'(`START_BALANCE);
            pot        <= '0;
        end else if (accept) begin
            case (transfer.award)
                poker_pkg::award_fold, poker_pkg::award_showdown: begin
                    pot <= '0;
                    if (transfer.winner == poker_pkg::p1) begin
                        p1_balance <= p1_paid + pot_paid;
                        p2_balance <= p2_paid;
                    end else begin
                        p1_balance <= p1_paid;
                        p2_balance <= p2_paid + pot_paid;
                    end
                end
                poker_pkg::award_split: begin
                    // Odd chip stays with p1.
                    pot        <= '0;
                    p1_balance <= p1_paid + (pot_paid - half_pot);
                    p2_balance <= p2_paid + half_pot;
                end
                default: begin
                    pot        <= pot_paid;
                    p1_balance <= p1_paid;
                    p2_balance <= p2_paid;
                end
            endcase
        end
    end

    assign ledger.p1_balance = p1_balance;
    assign ledger.p2_balance = p2_balance;
    assign ledger.pot        = pot;

endmodule

// File: logic/poker_table.sv
`timescale 1ns/10ps

module poker_table (
    input  logic                 clk,
    input  logic                 reset_d,
    input  poker_pkg::apb_req_s  apb_req,
    output poker_pkg::apb_rsp_s  apb_rsp
);

    logic                       action_strobe;
    poker_pkg::action_t         action;
    logic                       action_ok;
    logic                       cashout_req;
    logic                       freeze_req;
    poker_pkg::showdown_s       showdown;
    poker_pkg::table_state_t    table_state;
    logic                       new_table;
    logic                       hand_idle;
    poker_pkg::transfer_s       transfer;
    logic                       accept;
    poker_pkg::bet_status_s     bet_status;
    poker_pkg::ledger_s         ledger;

    apb_table_regs i_apb_table_regs (
        .clk           (clk),
        .reset_d       (reset_d),
        .apb_req       (apb_req),
        .apb_rsp       (apb_rsp),
        .action_strobe (action_strobe),
        .action        (action),
        .action_ok     (action_ok),
        .cashout_req   (cashout_req),
        .freeze_req    (freeze_req),
        .showdown      (showdown),
        .table_state   (table_state),
        .bet_status    (bet_status),
        .ledger        (ledger)
    );

    table_control i_table_control (
        .clk         (clk),
        .reset_d     (reset_d),
        .cashout_req (cashout_req),
        .freeze_req  (freeze_req),
        .hand_idle   (hand_idle),
        .table_state (table_state),
        .new_table   (new_table)
    );

    betting_engine i_betting_engine (
        .clk           (clk),
        .reset_d       (reset_d),
        .action_strobe (action_strobe),
        .action        (action),
        .table_state   (table_state),
        .new_table     (new_table),
        .showdown      (showdown),
        .transfer      (transfer),
        .accept        (accept),
        .action_ok     (action_ok),
        .hand_idle     (hand_idle),
        .bet_status    (bet_status)
    );

    chip_ledger i_chip_ledger (
        .clk       (clk),
        .reset_d   (reset_d),
        .new_table (new_table),
        .transfer  (transfer),
        .accept    (accept),
        .ledger    (ledger)
    );

endmodule

// File: tb/poker_table_asserts.sv
`timescale 1ns/10ps
`include "poker_params.svh"

module poker_table_asserts (
    input logic                    clk,
    input logic                    reset_d,
    input poker_pkg::apb_req_s     apb_req,
    input poker_pkg::apb_rsp_s     apb_rsp,
    input poker_pkg::ledger_s      ledger,
    input poker_pkg::table_state_t table_state
);

    logic access;

    assign access = apb_req.psel && apb_req.penable;

    // No wait states on this slave.
    a_pready: assert property (@(posedge clk) disable iff (reset_d) access |-> apb_rsp.pready)
        else $error("pready low in an APB access cycle");

    // Chips only move between the players and the pot.
    a_money: assert property (@(posedge clk) disable iff (reset_d)
        (10'(ledger.p1_balance) + 10'(ledger.p2_balance) + 10'(ledger.pot))
            <= 10'(2 * `START_BALANCE))
        else $error("pot plus balances exceeds the chips on the table");

    a_action_state: assert property (@(posedge clk) disable iff (reset_d)
        (access && apb_req.pwrite && apb_req.paddr == `ACTION_ADDR &&
         table_state != poker_pkg::playing) |-> apb_rsp.pslverr)
        else $error("action accepted outside the playing state");

endmodule

bind poker_table poker_table_asserts i_poker_table_asserts (
    .clk         (clk),
    .reset_d     (reset_d),
    .apb_req     (apb_req),
    .apb_rsp     (apb_rsp),
    .ledger      (ledger),
    .table_state (table_state)
);

// File: tb/tb_poker_table.sv
`timescale 1ns/10ps
`include "poker_params.svh"

module tb_poker_table;

    typedef struct packed {
        logic                ok;
        poker_pkg::ledger_s  led;
        poker_pkg::round_t   round;
        poker_pkg::player_t  cur_player;
        logic                parity;
        logic [`MONEY_W-1:0] cur_bet;
        logic [`MONEY_W-1:0] p1_com;
        logic [`MONEY_W-1:0] p2_com;
    } model_s;

    localparam int WAIT_LIMIT = 64;

    logic                    clk;
    logic                    reset_d;
    poker_pkg::apb_req_s     apb_req;
    poker_pkg::apb_rsp_s     apb_rsp;
    model_s                  model;
    poker_pkg::showdown_s    model_sd;
    poker_pkg::table_state_t model_state;
    poker_pkg::table_state_t saved_state;
    string                   test_name;
    int                      tests;
    int                      checks;
    int                      errors;
    int                      test_errors;
    int                      rejects;
    logic                    check_pending;
    logic [31:0]             rdata;
    logic                    slverr;
    logic [1:0]              rnd;

    poker_table i_poker_table (
        .clk     (clk),
        .reset_d (reset_d),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("Run stopped: %s", why);
        $display("Simulation FAILED");
        $finish;
    endtask

    task automatic apb_access(input logic write, input logic [`APB_AW-1:0] addr,
                              input logic [31:0] data);
        int waits;
        @(negedge clk);
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = write;
        apb_req.paddr   = addr;
        apb_req.pwdata  = data;
        @(negedge clk);
        apb_req.penable = 1'b1;
        waits = 0;
        #1;
        while (!apb_rsp.pready) begin
            if (waits == WAIT_LIMIT)
                abort_run("the APB slave never raised pready");
            @(negedge clk);
            #1;
            waits++;
        end
        rdata  = apb_rsp.prdata;
        slverr = apb_rsp.pslverr;
        @(negedge clk);
        apb_req = '0;
    endtask

    task automatic apb_write(input logic [`APB_AW-1:0] addr, input logic [31:0] data);
        apb_access(1'b1, addr, data);
    endtask

    task automatic apb_read(input logic [`APB_AW-1:0] addr);
        apb_access(1'b0, addr, 32'd0);
    endtask

    task automatic compare(input string what, input logic [31:0] expected,
                           input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            test_errors++;
            $display("Mismatch in %s (%s): expected 0x%08h, actual 0x%08h",
                     test_name, what, expected, actual);
        end
    endtask

    function automatic model_s fresh_model();
        model_s m;
        m                = '0;
        m.led.p1_balance = `MONEY_W'(`START_BALANCE);
        m.led.p2_balance = `MONEY_W'(`START_BALANCE);
        return m;
    endfunction

    // Reference for one action under the table rules.
    function automatic model_s model_step(input model_s m, input poker_pkg::action_t act,
                                          input poker_pkg::showdown_s sd,
                                          input poker_pkg::table_state_t st);
        model_s              n;
        poker_pkg::player_t  start;
        poker_pkg::player_t  other;
        poker_pkg::player_t  winner;
        logic [`MONEY_W-1:0] owed;
        logic [`MONEY_W-1:0] pay;
        logic [`MONEY_W-1:0] bal;
        logic [`MONEY_W-1:0] half;
        logic                advance;
        logic                end_hand;
        n        = m;
        n.ok     = 1'b0;
        start    = m.parity ? poker_pkg::p2 : poker_pkg::p1;
        other    = (m.cur_player == poker_pkg::p1) ? poker_pkg::p2 : poker_pkg::p1;
        winner   = other;
        owed     = m.cur_bet - ((m.cur_player == poker_pkg::p1) ? m.p1_com : m.p2_com);
        bal      = (m.cur_player == poker_pkg::p1) ? m.led.p1_balance : m.led.p2_balance;
        pay      = '0;
        advance  = 1'b0;
        end_hand = 1'b0;
        if (st != poker_pkg::playing || act == poker_pkg::act_none)
            return n;
        if (act == poker_pkg::act_raise) begin
            pay = owed + `MONEY_W'(`RAISE_STEP);
        end else if (act == poker_pkg::act_call) begin
            pay     = owed;
            advance = (m.cur_bet != '0) || (m.cur_player != start);
        end
        if (pay > bal)
            return n;
        n.ok = 1'b1;
        if (m.cur_player == poker_pkg::p1)
            n.led.p1_balance = bal - pay;
        else
            n.led.p2_balance = bal - pay;
        n.led.pot = m.led.pot + pay;
        if (act == poker_pkg::act_fold) begin
            end_hand = 1'b1;
        end else if (advance && m.round == poker_pkg::river) begin
            end_hand = 1'b1;
            winner   = sd.p1_wins ? poker_pkg::p1 : poker_pkg::p2;
        end
        if (end_hand && act == poker_pkg::act_call && sd.tie) begin
            half             = n.led.pot / 2;
            n.led.p2_balance = n.led.p2_balance + half;
            n.led.p1_balance = n.led.p1_balance + (n.led.pot - half);
        end else if (end_hand && winner == poker_pkg::p1) begin
            n.led.p1_balance = n.led.p1_balance + n.led.pot;
        end else if (end_hand) begin
            n.led.p2_balance = n.led.p2_balance + n.led.pot;
        end
        if (end_hand) begin
            n.led.pot    = '0;
            n.round      = poker_pkg::preflop;
            n.parity     = ~m.parity;
            n.cur_player = n.parity ? poker_pkg::p2 : poker_pkg::p1;
        end else if (advance) begin
            n.round      = poker_pkg::round_t'(m.round + 2'd1);
            n.cur_player = start;
        end else if (act == poker_pkg::act_raise) begin
            n.cur_bet    = m.cur_bet + `MONEY_W'(`RAISE_STEP);
            n.cur_player = other;
            if (m.cur_player == poker_pkg::p1)
                n.p1_com = n.cur_bet;
            else
                n.p2_com = n.cur_bet;
            return n;
        end else begin
            n.cur_player = other;
            return n;
        end
        n.cur_bet = '0;
        n.p1_com  = '0;
        n.p2_com  = '0;
        return n;
    endfunction

    function automatic logic [31:0] status_word(input model_s m,
                                                input poker_pkg::table_state_t st);
        logic [31:0] w;
        w          = '0;
        w[1:0]     = st;
        w[3:2]     = m.round;
        w[4]       = m.cur_player;
        w[11:5]    = m.cur_bet;
        w[18:12]   = m.led.pot;
        return w;
    endfunction

    // Reads back both status words against the model.
    always begin
        @(posedge clk);
        if (check_pending) begin
            apb_read(`STATUS_ADDR);
            compare("status", status_word(model, model_state), rdata);
            apb_read(`BALANCE_ADDR);
            compare("balance", {17'd0, model.led.p2_balance, 1'b0, model.led.p1_balance}, rdata);
            check_pending = 1'b0;
        end
    end

    task automatic verify();
        int waits;
        check_pending = 1'b1;
        waits = 0;
        while (check_pending) begin
            if (waits == WAIT_LIMIT)
                abort_run("the checker did not finish its readback");
            @(posedge clk);
            waits++;
        end
    endtask

    task automatic play(input poker_pkg::action_t a);
        model_s next;
        next = model_step(model, a, model_sd, model_state);
        apb_write(`ACTION_ADDR, {30'd0, a});
        compare("pslverr", {31'd0, !next.ok}, {31'd0, slverr});
        if (slverr)
            rejects++;
        model = next;
        verify();
    endtask

    task automatic set_showdown(input poker_pkg::showdown_s sd);
        apb_write(`SHOWDOWN_ADDR, {30'd0, sd});
        model_sd = sd;
    endtask

    // Levels stay applied, so settle the state over a few steps.
    task automatic set_control(input logic cash, input logic frz);
        poker_pkg::table_state_t nxt;
        apb_write(`CONTROL_ADDR, {30'd0, frz, cash});
        repeat (3) begin
            nxt = model_state;
            case (model_state)
                poker_pkg::playing: begin
                    if (frz)
                        nxt = poker_pkg::freeze;
                    else if (cash && model.round == poker_pkg::preflop && model.cur_bet == '0)
                        nxt = poker_pkg::cashout;
                end
                poker_pkg::cashout: begin
                    if (frz) begin
                        nxt = poker_pkg::freeze;
                    end else if (!cash) begin
                        nxt   = poker_pkg::playing;
                        model = fresh_model();
                    end
                end
                default: begin
                    if (!frz)
                        nxt = saved_state;
                end
            endcase
            if (nxt == poker_pkg::freeze && model_state != poker_pkg::freeze)
                saved_state = model_state;
            model_state = nxt;
        end
        verify();
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = 0;
    endtask

    task automatic end_test();
        tests++;
        $display("Test %s finished with %0d errors", test_name, test_errors);
    endtask

    initial begin
        reset_d       = 1'b1;
        apb_req       = '0;
        check_pending = 1'b0;
        tests         = 0;
        checks        = 0;
        errors        = 0;
        rejects       = 0;
        model         = fresh_model();
        model_sd      = '0;
        model_state   = poker_pkg::playing;
        saved_state   = poker_pkg::playing;
        void'($urandom(32'hf4a6_7887));
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset_d = 1'b0;

        start_test("reset_values");
        verify();
        end_test();

        start_test("checks_showdown");
        repeat (3) begin
            play(poker_pkg::act_call);
            play(poker_pkg::act_call);
        end
        set_showdown(2'b10);
        play(poker_pkg::act_raise);
        play(poker_pkg::act_call);
        end_test();

        start_test("raise_fold_tie");
        play(poker_pkg::act_raise);
        play(poker_pkg::act_raise);
        play(poker_pkg::act_call);
        play(poker_pkg::act_fold);
        set_showdown(2'b01);
        repeat (3) begin
            play(poker_pkg::act_call);
            play(poker_pkg::act_call);
        end
        play(poker_pkg::act_raise);
        play(poker_pkg::act_call);
        end_test();

        start_test("rejected");
        rejects = 0;
        repeat (8) play(poker_pkg::act_raise);
        compare("raise rejected", 32'd1, {31'd0, rejects != 0});
        play(poker_pkg::act_call);
        set_control(1'b0, 1'b1);
        play(poker_pkg::act_call);
        set_control(1'b0, 1'b0);
        end_test();

        start_test("cashout");
        set_control(1'b1, 1'b0);
        set_control(1'b0, 1'b0);
        play(poker_pkg::act_fold);
        set_control(1'b1, 1'b0);
        play(poker_pkg::act_call);
        set_control(1'b1, 1'b1);
        set_control(1'b1, 1'b0);
        set_control(1'b0, 1'b0);
        end_test();

        start_test("random");
        repeat (300) begin
            if ($urandom_range(0, 3) == 0) begin
                rnd = 2'($urandom_range(0, 3));
                set_showdown(poker_pkg::showdown_s'(rnd));
            end
            rnd = 2'($urandom_range(0, 3));
            play(poker_pkg::action_t'(rnd));
        end
        end_test();

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

// File: build.f
+incdir+common
common/poker_pkg.sv
logic/apb_table_regs.sv
logic/table_control.sv
betting/betting_engine.sv
betting/chip_ledger.sv
logic/poker_table.sv
tb/poker_table_asserts.sv
tb/tb_poker_table.sv

// File: Bender.yml
package:
  name: poker_table

export_include_dirs:
  - common

sources:
  - files:
      - common/poker_pkg.sv
      - logic/apb_table_regs.sv
      - logic/table_control.sv
      - betting/betting_engine.sv
      - betting/chip_ledger.sv
      - logic/poker_table.sv
  - target: test
    files:
      - tb/poker_table_asserts.sv
      - tb/tb_poker_table.sv
